// ==== include/opl_defs.svh ====
////////////////////////////////////////////////////////////////////////////
// FM operator bank sizing: slot count, data widths, timing and credits
////////////////////////////////////////////////////////////////////////////
`ifndef OPL_DEFS_SVH
`define OPL_DEFS_SVH

// single bank of operator slots
`define OPL_NUM_SLOTS     8
`define OPL_SLOT_BITS     3

// data path widths
`define OPL_PHASE_WIDTH   20
`define OPL_OP_OUT_WIDTH  13
`define OPL_ENV_WIDTH     9
`define OPL_WS_WIDTH      3
`define OPL_SAMPLE_WIDTH  16

// clocks per slot, and credits granted downstream after reset
`define OPL_SLOT_CYCLES   4
`define OPL_OUT_CREDITS   4

`endif

// ==== hdl/opl_cfg_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Register-side types: slot index, config writes, per-slot parameters
////////////////////////////////////////////////////////////////////////////
`include "opl_defs.svh"

package opl_cfg_pkg;

    typedef logic [`OPL_SLOT_BITS-1:0] slot_idx_t;

    // target register of a config write
    typedef enum logic [2:0] {
        FIELD_PHASE_INC,
        FIELD_WAVE_SEL,
        FIELD_ATTEN,
        FIELD_FLAGS,
        FIELD_KEY_ON
    } cfg_field_e;

    // one-cycle write strobe from the host side
    typedef struct packed {
        logic                          valid;
        slot_idx_t                     slot;
        cfg_field_e                    field;
        logic [`OPL_PHASE_WIDTH-1:0]   data;
    } cfg_write_t;

    typedef struct packed {
        logic [`OPL_PHASE_WIDTH-1:0]   phase_inc;
        logic [`OPL_WS_WIDTH-1:0]      ws;
        logic [`OPL_ENV_WIDTH-1:0]     env;
        // modulate from previous slot output
        logic                          fm;
        // slot contributes to the sample
        logic                          carrier;
        logic                          key_on_pending;
    } slot_param_t;

endpackage

// ==== hdl/opl_sample_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Data-path types: phase, operator output, attenuation, output sample
////////////////////////////////////////////////////////////////////////////
`include "opl_defs.svh"

package opl_sample_pkg;

    // phase accumulator value, wraps naturally
    typedef logic [`OPL_PHASE_WIDTH-1:0] phase_t;

    // signed operator output
    typedef logic signed [`OPL_OP_OUT_WIDTH-1:0] op_out_t;

    // attenuation, larger is quieter
    typedef logic [`OPL_ENV_WIDTH-1:0] atten_t;

    typedef logic signed [`OPL_SAMPLE_WIDTH-1:0] sample_t;

    // one frame result, valid for a single cycle
    typedef struct packed {
        logic    valid;
        sample_t sample;
    } sample_out_t;

endpackage

// ==== hdl/operator_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// Per-slot operator register file with key-on pulse capture
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "opl_defs.svh"

module operator_regs (
    input  logic                     clk,
    input  logic                     arst_n,
    input  opl_cfg_pkg::cfg_write_t  cfg,
    input  opl_cfg_pkg::slot_idx_t   slot,
    input  logic                     slot_start,
    output opl_cfg_pkg::slot_param_t param
);
    import opl_cfg_pkg::*;

    slot_param_t regs [`OPL_NUM_SLOTS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `OPL_NUM_SLOTS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // key-on is taken by the phase generator at slot start
            if (slot_start) begin
                regs[slot].key_on_pending <= 1'b0;
            end
            // a write in the same cycle wins over the clear
            if (cfg.valid) begin
                case (cfg.field)
                    FIELD_PHASE_INC: regs[cfg.slot].phase_inc <= cfg.data;
                    FIELD_WAVE_SEL:  regs[cfg.slot].ws <= cfg.data[`OPL_WS_WIDTH-1:0];
                    FIELD_ATTEN:     regs[cfg.slot].env <= cfg.data[`OPL_ENV_WIDTH-1:0];
                    FIELD_FLAGS: begin
                        // bit 0 fm, bit 1 carrier
                        regs[cfg.slot].fm      <= cfg.data[0];
                        regs[cfg.slot].carrier <= cfg.data[1];
                    end
                    FIELD_KEY_ON:    regs[cfg.slot].key_on_pending <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // current slot params, no pipeline
    assign param = regs[slot];

endmodule

// ==== hdl/slot_sequencer.sv ====
////////////////////////////////////////////////////////////////////////////
// Slot sequencer: walks all slots once per frame, frames gated by credit
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "opl_defs.svh"

module slot_sequencer (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   frame_ok,
    output opl_cfg_pkg::slot_idx_t slot,
    output logic                   slot_start,
    output logic                   frame_end
);
    import opl_cfg_pkg::*;

    localparam int CYC_W = $clog2(`OPL_SLOT_CYCLES);
    localparam logic [CYC_W-1:0] LAST_CYC = CYC_W'(`OPL_SLOT_CYCLES - 1);
    localparam slot_idx_t LAST_SLOT = slot_idx_t'(`OPL_NUM_SLOTS - 1);

    typedef enum logic {IDLE, RUN} seq_state_e;

    seq_state_e       state;
    logic [CYC_W-1:0] cyc;
    slot_idx_t        slot_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= IDLE;
            cyc    <= '0;
            slot_q <= '0;
        end else begin
            case (state)
                IDLE: begin
                    cyc    <= '0;
                    slot_q <= '0;
                    if (frame_ok) state <= RUN;
                end
                RUN: begin
                    cyc <= cyc + 1'b1;
                    if (cyc == LAST_CYC) begin
                        if (slot_q == LAST_SLOT) begin
                            slot_q <= '0;
                            // back to back frames while credit remains
                            if (!frame_ok) state <= IDLE;
                        end else begin
                            slot_q <= slot_q + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign slot       = slot_q;
    assign slot_start = (state == RUN) && (cyc == '0);
    assign frame_end  = (state == RUN) && (cyc == LAST_CYC) && (slot_q == LAST_SLOT);

endmodule

// ==== hdl/wave_tables.sv ====
////////////////////////////////////////////////////////////////////////////
// Quarter-wave log-sine ROM and exponential ROM, built at elaboration
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module wave_tables (
    input  logic [7:0]  log_sin_idx,
    output logic [11:0] log_sin,
    input  logic [7:0]  exp_idx,
    output logic [9:0]  exp_val
);
    localparam int DEPTH = 256;
    localparam real PI = 3.14159265358979;

    // -log2(sin) in 1/256 steps over a quarter wave
    function automatic logic [11:0] log_sin_entry(input int i);
        real s;
        real lg;
        s  = $sin((i + 0.5) * PI / 512.0);
        lg = -$ln(s) / $ln(2.0);
        return 12'($rtoi(lg * 256.0 + 0.5));
    endfunction

    // fractional part of 2^x scaled to 10 bits
    function automatic logic [9:0] exp_entry(input int i);
        real e;
        e = $pow(2.0, i / 256.0) - 1.0;
        return 10'($rtoi(e * 1024.0 + 0.5));
    endfunction

    logic [11:0] log_sin_rom [DEPTH];
    logic [9:0]  exp_rom [DEPTH];

    for (genvar i = 0; i < DEPTH; i++) begin : g_rom
        assign log_sin_rom[i] = log_sin_entry(i);
        assign exp_rom[i]     = exp_entry(i);
    end

    assign log_sin = log_sin_rom[log_sin_idx];
    assign exp_val = exp_rom[exp_idx];

endmodule

// ==== hdl/phase_generator.sv ====
////////////////////////////////////////////////////////////////////////////
// Phase generator: per-slot phase accumulation, FM, log/exp wave synthesis
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "opl_defs.svh"

module phase_generator (
    input  logic                     clk,
    input  logic                     arst_n,
    input  opl_cfg_pkg::slot_idx_t   slot,
    input  logic                     slot_start,
    input  opl_cfg_pkg::slot_param_t param,
    output opl_sample_pkg::op_out_t  op_out,
    output logic                     op_valid,
    output logic                     op_carrier
);
    import opl_sample_pkg::*;

    localparam int TOP = `OPL_PHASE_WIDTH - 1;
    localparam int MOD_SHIFT = `OPL_PHASE_WIDTH - `OPL_OP_OUT_WIDTH;
    localparam op_out_t OUT_MAX = op_out_t'(2**(`OPL_OP_OUT_WIDTH-1) - 1);
    localparam op_out_t OUT_MIN = op_out_t'(-(2**(`OPL_OP_OUT_WIDTH-1)));

    phase_t acc [`OPL_NUM_SLOTS];
    logic   odd_period [`OPL_NUM_SLOTS];
    logic   msb_last [`OPL_NUM_SLOTS];

    phase_t                   final_phase;
    logic [`OPL_WS_WIDTH-1:0] ws_q;
    atten_t                   env_q;
    logic                     carrier_q;
    logic                     stage1_q;
    logic                     stage2_q;

    phase_t      inc;
    phase_t      acc_next;
    phase_t      mod_phase;
    logic [7:0]  quarter_idx;
    logic [7:0]  ramp_idx;
    logic [11:0] ramp;
    logic [11:0] log_sin;
    logic [12:0] gain;
    logic [9:0]  exp_val;
    logic [12:0] mant;
    logic [12:0] shifted;
    op_out_t     sine;
    op_out_t     abs_sine;
    op_out_t     odd_sine;
    op_out_t     shaped;

    // cycle 0 inputs, ws 4 and 5 run at double rate
    always_comb begin
        inc = (param.ws == 3'd4 || param.ws == 3'd5) ? param.phase_inc << 1 : param.phase_inc;
        acc_next = acc[slot] + inc;
        // op_out still holds the previous slot
        mod_phase = param.fm ? {op_out, {MOD_SHIFT{1'b0}}} : '0;
    end

    // quarter wave mirrored in second and fourth quadrant
    assign quarter_idx = final_phase[TOP-1] ? ~final_phase[TOP-2:TOP-9] : final_phase[TOP-2:TOP-9];

    // ws 7 ramp, upper bit mutes quadrants 2 and 3
    assign ramp_idx = final_phase[TOP] ? ~final_phase[TOP-2:TOP-9] : final_phase[TOP-2:TOP-9];
    assign ramp = {final_phase[TOP] ^ final_phase[TOP-1], ramp_idx, 3'b000};

    wave_tables wave_tables_inst (
        .log_sin_idx (quarter_idx),
        .log_sin     (log_sin),
        .exp_idx     (~gain[7:0]),
        .exp_val     (exp_val)
    );

    always_comb begin
        gain = (ws_q == 3'd7 ? ramp : log_sin) + {env_q, 3'b000};
        // (1024 + exp) * 2, then integer part of log as right shift
        mant = {2'b01, exp_val, 1'b0};
        shifted = mant >> gain[12:8];
        sine = final_phase[TOP] ? op_out_t'(~shifted) : op_out_t'(shifted);
        abs_sine = sine < 0 ? ~sine : sine;
        odd_sine = odd_period[slot] ? sine : '0;
    end

    always_comb begin
        case (ws_q)
            3'd0: shaped = sine;
            3'd1: shaped = sine < 0 ? '0 : sine;
            3'd2: shaped = abs_sine;
            3'd3: shaped = final_phase[TOP-1] ? '0 : abs_sine;
            3'd4: shaped = odd_sine;
            3'd5: shaped = odd_sine < 0 ? ~odd_sine : odd_sine;
            3'd6: shaped = sine > 0 ? OUT_MAX : OUT_MIN;
            default: shaped = sine;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `OPL_NUM_SLOTS; i++) begin
                acc[i]        <= '0;
                odd_period[i] <= 1'b0;
                msb_last[i]   <= 1'b0;
            end
            final_phase <= '0;
            ws_q        <= '0;
            env_q       <= '0;
            carrier_q   <= 1'b0;
            stage1_q    <= 1'b0;
            stage2_q    <= 1'b0;
            op_out      <= '0;
            op_valid    <= 1'b0;
            op_carrier  <= 1'b0;
        end else begin
            stage1_q <= slot_start;
            stage2_q <= stage1_q;
            op_valid <= stage2_q;
            if (slot_start) begin
                ws_q      <= param.ws;
                env_q     <= param.env;
                carrier_q <= param.carrier;
                if (param.key_on_pending) begin
                    acc[slot]   <= '0;
                    final_phase <= '0;
                end else begin
                    acc[slot]   <= acc_next;
                    final_phase <= acc_next + mod_phase;
                end
            end
            // odd period flips on each rising edge of the phase msb
            if (stage1_q) begin
                msb_last[slot] <= final_phase[TOP];
                if (final_phase[TOP] && !msb_last[slot]) begin
                    odd_period[slot] <= ~odd_period[slot];
                end
            end
            if (stage2_q) begin
                op_out     <= shaped;
                op_carrier <= carrier_q;
            end
        end
    end

endmodule

// ==== hdl/sample_mixer.sv ====
////////////////////////////////////////////////////////////////////////////
// Carrier mixer: frame sum, saturation and credit-gated sample output
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "opl_defs.svh"

module sample_mixer (
    input  logic                        clk,
    input  logic                        arst_n,
    input  opl_sample_pkg::op_out_t     op_out,
    input  logic                        op_valid,
    input  logic                        op_carrier,
    input  logic                        frame_end,
    input  logic                        credit_return,
    output logic                        frame_ok,
    output opl_sample_pkg::sample_out_t sample_out
);
    import opl_sample_pkg::*;

    // headroom for every slot at full scale plus a guard bit
    localparam int SUM_W = `OPL_OP_OUT_WIDTH + `OPL_SLOT_BITS + 1;
    localparam int CREDIT_W = $clog2(`OPL_OUT_CREDITS + 1) + 1;
    localparam logic signed [SUM_W-1:0] SAT_HI = 2**(`OPL_SAMPLE_WIDTH-1) - 1;
    localparam logic signed [SUM_W-1:0] SAT_LO = -(2**(`OPL_SAMPLE_WIDTH-1));

    logic signed [SUM_W-1:0] sum;
    logic signed [SUM_W-1:0] addend;
    logic signed [SUM_W-1:0] sum_next;
    sample_t                 sat;
    logic [CREDIT_W-1:0]     credits;
    logic                    in_flight;

    always_comb begin
        addend   = (op_valid && op_carrier) ? SUM_W'(op_out) : '0;
        sum_next = sum + addend;
        if (sum_next > SAT_HI) sat = sample_t'(SAT_HI);
        else if (sum_next < SAT_LO) sat = sample_t'(SAT_LO);
        else sat = sample_t'(sum_next);
    end

    // slot 7 lands in the frame_end cycle, so sum_next is complete there
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum        <= '0;
            sample_out <= '0;
        end else begin
            sample_out.valid <= frame_end;
            if (frame_end) begin
                sample_out.sample <= sat;
                sum <= '0;
            end else begin
                sum <= sum_next;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= CREDIT_W'(`OPL_OUT_CREDITS);
        end else begin
            credits <= credits + CREDIT_W'(credit_return) - CREDIT_W'(sample_out.valid);
        end
    end

    // a finished frame holds its credit until the count drops
    assign in_flight = frame_end | sample_out.valid;
    assign frame_ok  = credits > CREDIT_W'(in_flight);

endmodule

// ==== hdl/fm_operator_top.sv ====
////////////////////////////////////////////////////////////////////////////
// FM operator bank top level: sequencer, registers, operator and mixer
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fm_operator_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  opl_cfg_pkg::cfg_write_t     cfg,
    input  logic                        credit_return,
    output opl_sample_pkg::sample_out_t sample_out
);
    import opl_cfg_pkg::*;
    import opl_sample_pkg::*;

    slot_idx_t   slot;
    logic        slot_start;
    logic        frame_end;
    logic        frame_ok;
    slot_param_t param;
    op_out_t     op_out;
    logic        op_valid;
    logic        op_carrier;

    slot_sequencer slot_sequencer_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .frame_ok   (frame_ok),
        .slot       (slot),
        .slot_start (slot_start),
        .frame_end  (frame_end)
    );

    operator_regs operator_regs_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .cfg        (cfg),
        .slot       (slot),
        .slot_start (slot_start),
        .param      (param)
    );

    phase_generator phase_generator_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .slot       (slot),
        .slot_start (slot_start),
        .param      (param),
        .op_out     (op_out),
        .op_valid   (op_valid),
        .op_carrier (op_carrier)
    );

    sample_mixer sample_mixer_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .op_out        (op_out),
        .op_valid      (op_valid),
        .op_carrier    (op_carrier),
        .frame_end     (frame_end),
        .credit_return (credit_return),
        .frame_ok      (frame_ok),
        .sample_out    (sample_out)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench clock source, free running from time zero
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);
    // starts low, so the first rising edge lands at half a period
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

// ==== verification/fm_operator_assertions.sv ====
////////////////////////////////////////////////////////////////////////////
// Bound checks on the sample credit handshake and slot sequencing
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "opl_defs.svh"

module fm_operator_assertions (
    input logic                                  clk,
    input logic                                  arst_n,
    input opl_cfg_pkg::slot_idx_t                slot,
    input logic                                  slot_start,
    input logic                                  frame_end,
    input opl_sample_pkg::sample_out_t           sample_out,
    input logic [$clog2(`OPL_OUT_CREDITS + 1):0] credits
);
    import opl_cfg_pkg::*;

    localparam slot_idx_t LAST_SLOT = slot_idx_t'(`OPL_NUM_SLOTS - 1);

    // a sample only leaves while downstream still has room
    a_sample_needs_credit: assert property (
        @(posedge clk) disable iff (!arst_n)
        sample_out.valid |-> credits != '0
    ) else $error("sample sent with no credit left");

    // inside a frame each slot lasts exactly four cycles
    a_slot_period: assert property (
        @(posedge clk) disable iff (!arst_n)
        (slot_start && slot != LAST_SLOT) |=> !slot_start [*3] ##1 slot_start
    ) else $error("slot start spacing broken within a frame");

    // mixer result follows the end of the frame
    a_frame_to_sample: assert property (
        @(posedge clk) disable iff (!arst_n)
        frame_end |=> sample_out.valid
    ) else $error("frame end not followed by a sample");

endmodule

// ==== verification/fm_operator_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// FM operator bank testbench checking random programming against a frame model
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "opl_defs.svh"

module fm_operator_tb;
    import opl_cfg_pkg::*;
    import opl_sample_pkg::*;

    localparam int FRAME_CYCLES = `OPL_NUM_SLOTS * `OPL_SLOT_CYCLES;
    localparam int RESET_CYCLES = 10;
    localparam int TIMEOUT_CYCLES = 64 * FRAME_CYCLES * 3 + RESET_CYCLES;

    logic        clk;
    logic        arst_n;
    cfg_write_t  cfg;
    logic        credit_return;
    sample_out_t sample_out;

    int seed = 89640;
    int errors = 0;
    int samples_received = 0;
    int credits_given = 0;
    int cycles = 0;
    int reset_done_cycle = 0;
    int exp_q[$];

    // reference tables and per-slot model state
    int          log_sin_tab [256];
    int          exp_tab [256];
    logic [19:0] m_inc [`OPL_NUM_SLOTS];
    logic [19:0] m_acc [`OPL_NUM_SLOTS];
    int          m_ws [`OPL_NUM_SLOTS];
    int          m_env [`OPL_NUM_SLOTS];
    logic        m_fm [`OPL_NUM_SLOTS];
    logic        m_car [`OPL_NUM_SLOTS];
    logic        m_key [`OPL_NUM_SLOTS];
    logic        m_odd [`OPL_NUM_SLOTS];
    logic        m_msb [`OPL_NUM_SLOTS];
    int          prev_out = 0;

    tb_clock_gen #(.PERIOD_NS(4.0)) tb_clock_gen_inst (.clk(clk));

    fm_operator_top fm_operator_top_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .cfg           (cfg),
        .credit_return (credit_return),
        .sample_out    (sample_out)
    );

    bind fm_operator_top fm_operator_assertions fm_operator_assertions_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .slot       (slot),
        .slot_start (slot_start),
        .frame_end  (frame_end),
        .sample_out (sample_out),
        .credits    (sample_mixer_inst.credits)
    );

    // fixed point -log2(sin) over a quarter wave and 2^x - 1
    function automatic void build_tables();
        real s;
        for (int i = 0; i < 256; i++) begin
            s = $sin((i + 0.5) * 3.14159265358979 / 512.0);
            log_sin_tab[i] = $rtoi(-$ln(s) / $ln(2.0) * 256.0 + 0.5);
            exp_tab[i] = $rtoi(($pow(2.0, i / 256.0) - 1.0) * 1024.0 + 0.5);
        end
    endfunction

    // one operator output from its final phase
    function automatic int operator_value(input logic [19:0] ph, input int ws,
                                          input int env, input logic odd);
        int idx;
        int lvl;
        int mag;
        int sine;
        idx = ph[17:10];
        if (ph[18]) idx = 255 - idx;
        if (ws == 7) begin
            // linear ramp in place of the log-sine value
            lvl = ph[19] ? 255 - ph[17:10] : ph[17:10];
            lvl = lvl * 8 + ((ph[19] ^ ph[18]) ? 2048 : 0);
        end else begin
            lvl = log_sin_tab[idx];
        end
        lvl = lvl + env * 8;
        // fraction through the exp table and integer part as a right shift
        mag = ((1024 + exp_tab[255 - (lvl % 256)]) * 2) >> (lvl / 256);
        sine = ph[19] ? -mag - 1 : mag;
        case (ws)
            1: return ph[19] ? 0 : mag;
            2: return mag;
            3: return ph[18] ? 0 : mag;
            4: return odd ? sine : 0;
            5: return odd ? mag : 0;
            6: return (sine > 0) ? 4095 : -4096;
            default: return sine;
        endcase
    endfunction

    // walks all slots of one frame and returns the saturated carrier sum
    function automatic int model_frame();
        int          sum;
        logic [19:0] inc;
        logic [19:0] fin;
        logic [12:0] mod_bits;
        sum = 0;
        for (int s = 0; s < `OPL_NUM_SLOTS; s++) begin
            inc = (m_ws[s] == 4 || m_ws[s] == 5) ? m_inc[s] << 1 : m_inc[s];
            mod_bits = prev_out[12:0];
            if (m_key[s]) begin
                m_acc[s] = '0;
                fin = '0;
                m_key[s] = 1'b0;
            end else begin
                m_acc[s] = m_acc[s] + inc;
                fin = m_acc[s] + (m_fm[s] ? {mod_bits, 7'b0} : 20'd0);
            end
            // odd period follows rising edges of the phase msb
            if (fin[19] && !m_msb[s]) m_odd[s] = ~m_odd[s];
            m_msb[s] = fin[19];
            prev_out = operator_value(fin, m_ws[s], m_env[s], m_odd[s]);
            if (m_car[s]) sum += prev_out;
        end
        if (sum > 32767) sum = 32767;
        if (sum < -32768) sum = -32768;
        return sum;
    endfunction

    // one-cycle config strobe driven from a falling edge
    task automatic write_reg(input int s, input cfg_field_e field, input logic [19:0] data);
        cfg.valid = 1'b1;
        cfg.slot = slot_idx_t'(s);
        cfg.field = field;
        cfg.data = data;
        case (field)
            FIELD_PHASE_INC: m_inc[s] = data;
            FIELD_WAVE_SEL:  m_ws[s] = data[2:0];
            FIELD_ATTEN:     m_env[s] = data[8:0];
            FIELD_FLAGS: begin
                m_fm[s] = data[0];
                m_car[s] = data[1];
            end
            default: m_key[s] = 1'b1;
        endcase
        @(negedge clk);
        cfg = '0;
    endtask

    task automatic program_slot(input int s, input int ws, input int env, input int flags);
        write_reg(s, FIELD_PHASE_INC, 20'($random(seed)));
        write_reg(s, FIELD_WAVE_SEL, 20'(ws));
        write_reg(s, FIELD_ATTEN, 20'(env));
        write_reg(s, FIELD_FLAGS, 20'(flags));
    endtask

    // downstream frees one buffer per credit after a random gap
    task automatic run_round(input int frames);
        int gap;
        for (int f = 0; f < frames; f++) exp_q.push_back(model_frame());
        for (int c = 0; c < frames; c++) begin
            gap = ($random(seed) & 32'h7fff_ffff) % 41;
            repeat (gap) @(negedge clk);
            while (samples_received <= credits_given) @(negedge clk);
            credit_return = 1'b1;
            credits_given++;
            @(negedge clk);
            credit_return = 1'b0;
        end
        while (samples_received < credits_given + `OPL_OUT_CREDITS) @(negedge clk);
    endtask

    // registered outputs read away from the rising edge
    always @(negedge clk) begin
        int got;
        if (arst_n && sample_out.valid) begin
            got = sample_out.sample;
            if (samples_received == 0 && cycles - reset_done_cycle < FRAME_CYCLES + 1) begin
                $display("sample appeared before the first frame could finish");
                errors++;
            end
            if (exp_q.size() == 0) begin
                $display("Error at %0t: unexpected sample %0d", $time, got);
                errors++;
            end else if (got != exp_q[0]) begin
                $display("Error at %0t: sample %0d got %0d expected %0d",
                         $time, samples_received, got, exp_q[0]);
                errors++;
                void'(exp_q.pop_front());
            end else begin
                void'(exp_q.pop_front());
            end
            samples_received++;
            if (samples_received - credits_given > `OPL_OUT_CREDITS) begin
                $display("more samples sent than the downstream buffer can hold");
                errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // run limit for a DUT that stops producing samples
    initial begin
        wait (cycles >= TIMEOUT_CYCLES);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int base;
        cfg = '0;
        credit_return = 1'b0;
        arst_n = 1'b0;
        build_tables();
        for (int s = 0; s < `OPL_NUM_SLOTS; s++) begin
            m_inc[s] = '0;
            m_acc[s] = '0;
            m_ws[s] = 0;
            m_env[s] = 0;
            m_fm[s] = 1'b0;
            m_car[s] = 1'b0;
            m_key[s] = 1'b0;
            m_odd[s] = 1'b0;
            m_msb[s] = 1'b0;
        end
        // reset credits run four silent unprogrammed frames
        for (int f = 0; f < `OPL_OUT_CREDITS; f++) exp_q.push_back(model_frame());
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        reset_done_cycle = cycles;
        while (samples_received < `OPL_OUT_CREDITS) @(negedge clk);
        // nothing more may leave while credit is withheld
        repeat (3 * FRAME_CYCLES) @(negedge clk);
        if (samples_received != `OPL_OUT_CREDITS) begin
            $display("Error at %0t: %0d samples seen with credit withheld",
                     $time, samples_received);
            errors++;
        end
        // plain sine carriers without modulation
        for (int s = 0; s < `OPL_NUM_SLOTS; s++) begin
            program_slot(s, 0, $random(seed) & 15, ($random(seed) & 1) << 1);
        end
        run_round(6);
        // every waveform once per round with odd slots modulated
        repeat (2) begin
            base = $random(seed) & 7;
            for (int s = 0; s < `OPL_NUM_SLOTS; s++) begin
                program_slot(s, (s + base) % 8, $random(seed) & 31,
                             (($random(seed) & 1) << 1) | (s & 1));
            end
            run_round(6);
        end
        // phase restart on a few slots
        write_reg(1, FIELD_KEY_ON, '0);
        write_reg($random(seed) & 7, FIELD_KEY_ON, '0);
        write_reg($random(seed) & 7, FIELD_KEY_ON, '0);
        run_round(4);
        // everything random over the full attenuation range
        for (int s = 0; s < `OPL_NUM_SLOTS; s++) begin
            program_slot(s, $random(seed) & 7, $random(seed) & 511, $random(seed) & 3);
        end
        write_reg($random(seed) & 7, FIELD_KEY_ON, '0);
        run_round(8);
        // idle tail where any extra sample shows up as unexpected
        repeat (2 * FRAME_CYCLES) @(negedge clk);
        $display("%0d samples checked, %0d errors", samples_received, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
hdl/opl_cfg_pkg.sv
hdl/opl_sample_pkg.sv
hdl/operator_regs.sv
hdl/slot_sequencer.sv
hdl/wave_tables.sv
hdl/phase_generator.sv
hdl/sample_mixer.sv
hdl/fm_operator_top.sv
verification/tb_clock_gen.sv
verification/fm_operator_assertions.sv
verification/fm_operator_tb.sv
